/* control_unit.f */
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/operand_latch.sv
hdl/micro_sequencer.sv
hdl/control_word_encoder.sv
hdl/control_unit.sv
verification/control_unit_checks.sv
verification/control_unit_tb.sv

/* hdl/control_unit.sv */
module control_unit (
        input  logic              clk,
        input  logic              rst_n,
        input  logic              z,
        input  ctrl_pkg::instr_t  instruction,
        output ctrl_pkg::wr_en_t  write_enable,
        output ctrl_pkg::rd_sel_t read_enable,
        output ctrl_pkg::inc_en_t increment,
        output ctrl_pkg::alu_op_t alu,
        output logic              finish
);
        import ctrl_pkg::*;

        decoded_instr_t decoded;
        operand_t       held;
        ctrl_state_t    state;
        opcode_t        op_now;
        logic           dispatch;
        ctrl_word_t     word;

        instr_decoder i_decoder (
                .instruction (instruction),
                .decoded     (decoded)
        );

        operand_latch i_operand_latch (
                .clk      (clk),
                .rst_n    (rst_n),
                .dispatch (dispatch),
                .operand  (decoded.operand),
                .held     (held)
        );

        micro_sequencer i_sequencer (
                .clk      (clk),
                .rst_n    (rst_n),
                .z        (z),
                .decoded  (decoded),
                .state    (state),
                .op_now   (op_now),
                .dispatch (dispatch)
        );

        control_word_encoder i_encoder (
                .state  (state),
                .op_now (op_now),
                .held   (held),
                .word   (word)
        );

        assign write_enable = word.wr_en;
        assign read_enable  = word.rd_sel;
        assign increment    = word.inc_en;
        assign alu          = word.alu;
        assign finish       = word.finish;

endmodule

/* hdl/control_word_encoder.sv */
module control_word_encoder (
        input  ctrl_pkg::ctrl_state_t state,
        input  ctrl_pkg::opcode_t     op_now,
        input  ctrl_pkg::operand_t    held,
        output ctrl_pkg::ctrl_word_t  word
);
        import ctrl_pkg::*;

        function automatic wr_en_t reg_write(reg_sel_t sel);
                wr_en_t bits;
                bits = '0;
                if (sel != REG_NONE)
                        bits[WR_REG_BASE + int'(sel)] = 1'b1;
                return bits;
        endfunction

        function automatic rd_sel_t reg_read(reg_sel_t sel);
                rd_sel_t code;
                code = RD_NONE;
                if (sel != REG_NONE)
                        code = RD_REG_BASE + rd_sel_t'(sel);
                return code;
        endfunction

        function automatic rd_sel_t add_source(add_sel_t src);
                rd_sel_t code;
                case (src)
                        ADD_SRC_R:  code = reg_read(REG_R);
                        ADD_SRC_R1: code = reg_read(REG_R1);
                        ADD_SRC_R2: code = reg_read(REG_R2);
                        default:    code = RD_NONE;
                endcase
                return code;
        endfunction

        always_comb
        begin
                word        = '0;
                word.rd_sel = RD_NONE;
                word.alu    = ALU_NO_OP;
                case (state)
                        ST_FETCH1:  word.rd_sel = RD_INS_MEM;
                        ST_FETCH2:
                        begin
                                word.rd_sel       = RD_INS_MEM;
                                word.wr_en[WR_IR] = 1'b1;
                        end
                        ST_FETCH3:  word.inc_en[INC_PC] = 1'b1;

                        ST_ADD1:
                        begin
                                word.rd_sel = add_source(held.add_sel);
                                word.alu    = ALU_ADD;
                        end
                        ST_SUB1:
                        begin
                                word.rd_sel = reg_read(REG_R);
                                word.alu    = ALU_SUB;
                        end
                        ST_CLAC1:   word.alu = ALU_ZERO;
                        ST_SFTR1:   word.alu = ALU_SFTR;
                        ST_SFTL1:   word.alu = ALU_SFTL;
                        ST_ADD2, ST_SUB2, ST_ALU_WB:
                                word.wr_en[WR_ALU_AC] = 1'b1;   // ALU result into AC.

                        ST_LDACAR1:
                        begin
                                word.rd_sel = RD_DATA_MEM;
                                word.wr_en  = reg_write(REG_DR);
                        end
                        ST_LDACAR2:
                        begin
                                word.rd_sel       = reg_read(REG_DR);
                                word.wr_en[WR_AC] = 1'b1;
                        end

                        ST_EXEC1:
                        begin
                                case (op_now)
                                        OP_MVAC:
                                        begin
                                                word.rd_sel = RD_AC;
                                                word.wr_en  = reg_write(held.reg_sel);
                                        end
                                        OP_MOVREG:
                                        begin
                                                word.rd_sel       = reg_read(held.reg_sel);
                                                word.wr_en[WR_AC] = 1'b1;
                                        end
                                        OP_INCAC: word.inc_en[INC_AC] = 1'b1;
                                        OP_INCR:  word.inc_en[INC_R]  = 1'b1;
                                        OP_INCR3: word.inc_en[INC_R3] = 1'b1;
                                        default:  word.alu = ALU_NO_OP;  // NOP or the jump idle cycle.
                                endcase
                        end

                        ST_JUMP1:   word.rd_sel = RD_INS_MEM;
                        ST_JUMP2:
                        begin
                                word.rd_sel       = RD_INS_MEM;
                                word.wr_en[WR_IR] = 1'b1;
                        end
                        ST_JUMP3:   word.wr_en[WR_IR_PC] = 1'b1;
                        ST_SKIP:    word.inc_en[INC_PC]  = 1'b1;  // Step over the target word.
                        ST_ENDOP:   word.finish = 1'b1;
                        default:    word.rd_sel = RD_NONE;
                endcase
        end

        // --------------------
        // Assertions

        always_comb
        begin
                wr_onehot: assert final ($onehot0(word.wr_en))
                        else $error("More than one write enable set.");
                inc_onehot: assert final ($onehot0(word.inc_en))
                        else $error("More than one increment set.");
        end

endmodule

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

        // --------------------
        // Instruction format

        typedef logic [15:0] instr_t;

        localparam int OPCODE_MSB = 15;
        localparam int OPCODE_LSB = 8;
        localparam int SEL_MSB    = 3;
        localparam int SEL_LSB    = 0;
        localparam int ADD_MSB    = 1;
        localparam int ADD_LSB    = 0;

        typedef enum logic [7:0] {
                OP_NOP    = 8'd4,
                OP_ADD    = 8'd5,
                OP_SUB    = 8'd9,
                OP_LDACAR = 8'd16,
                OP_MVAC   = 8'd20,
                OP_MOVREG = 8'd21,
                OP_CLAC   = 8'd22,
                OP_JUMP   = 8'd24,
                OP_JUMPZ  = 8'd27,
                OP_JMNZ   = 8'd29,
                OP_INCAC  = 8'd31,
                OP_INCR   = 8'd32,
                OP_INCR3  = 8'd33,
                OP_SFTR   = 8'd34,
                OP_SFTL   = 8'd36,
                OP_ENDOP  = 8'd40
        } opcode_t;

        typedef logic [3:0] reg_sel_t;     // 1 is X, 11 is DR.
        typedef logic [1:0] add_sel_t;

        localparam reg_sel_t REG_NONE  = 4'd0;
        localparam reg_sel_t REG_FIRST = 4'd1;
        localparam reg_sel_t REG_R     = 4'd7;
        localparam reg_sel_t REG_R1    = 4'd8;
        localparam reg_sel_t REG_R2    = 4'd9;
        localparam reg_sel_t REG_DR    = 4'd11;
        localparam reg_sel_t REG_LAST  = 4'd11;

        localparam add_sel_t ADD_SRC_R  = 2'd1;
        localparam add_sel_t ADD_SRC_R1 = 2'd2;
        localparam add_sel_t ADD_SRC_R2 = 2'd3;

        typedef struct packed {
                reg_sel_t reg_sel;
                add_sel_t add_sel;
        } operand_t;

        typedef struct packed {
                logic     known;
                opcode_t  opcode;
                operand_t operand;
        } decoded_instr_t;

        // --------------------
        // Control word

        typedef logic [14:0] wr_en_t;
        typedef logic [3:0]  rd_sel_t;
        typedef logic [3:0]  inc_en_t;

        localparam int WR_ALU_AC   = 0;
        localparam int WR_IR_PC    = 1;
        localparam int WR_IR       = 2;
        localparam int WR_REG_BASE = 2;    // Register n writes bit n + 2.
        localparam int WR_AC       = 14;

        localparam rd_sel_t RD_NONE     = 4'd0;
        localparam rd_sel_t RD_INS_MEM  = 4'd1;
        localparam rd_sel_t RD_DATA_MEM = 4'd2;
        localparam rd_sel_t RD_AC       = 4'd3;
        localparam rd_sel_t RD_REG_BASE = 4'd3;

        localparam int INC_PC = 0;
        localparam int INC_AC = 1;
        localparam int INC_R  = 2;
        localparam int INC_R3 = 3;

        typedef enum logic [2:0] {
                ALU_NO_OP = 3'd0,
                ALU_ADD   = 3'd1,
                ALU_SUB   = 3'd3,
                ALU_SFTR  = 3'd4,
                ALU_SFTL  = 3'd5,
                ALU_ZERO  = 3'd6
        } alu_op_t;

        typedef enum logic [4:0] {
                ST_FETCH1, ST_FETCH2, ST_FETCH3,
                ST_ADD1, ST_ADD2, ST_SUB1, ST_SUB2, ST_ALU_WB,
                ST_CLAC1, ST_SFTR1, ST_SFTL1, ST_LDACAR1, ST_LDACAR2,
                ST_EXEC1, ST_JUMP1, ST_JUMP2, ST_JUMP3, ST_SKIP,
                ST_ENDOP
        } ctrl_state_t;

        typedef struct packed {
                wr_en_t  wr_en;
                rd_sel_t rd_sel;
                inc_en_t inc_en;
                alu_op_t alu;
                logic    finish;
        } ctrl_word_t;

endpackage

/* hdl/instr_decoder.sv */
module instr_decoder (
        input  ctrl_pkg::instr_t         instruction,
        output ctrl_pkg::decoded_instr_t decoded
);
        import ctrl_pkg::*;

        logic [7:0] op_byte;
        reg_sel_t   sel_raw;
        reg_sel_t   sel_folded;
        logic       known;

        assign op_byte = instruction[OPCODE_MSB:OPCODE_LSB];
        assign sel_raw = instruction[SEL_MSB:SEL_LSB];

        always_comb
        begin
                case (op_byte)
                        OP_NOP, OP_ADD, OP_SUB, OP_LDACAR,
                        OP_MVAC, OP_MOVREG, OP_CLAC,
                        OP_JUMP, OP_JUMPZ, OP_JMNZ,
                        OP_INCAC, OP_INCR, OP_INCR3,
                        OP_SFTR, OP_SFTL, OP_ENDOP:
                                known = 1'b1;
                        default:
                                known = 1'b0;
                endcase
        end

        // Selectors that name no register collapse to zero here.
        always_comb
        begin
                if (sel_raw >= REG_FIRST && sel_raw <= REG_LAST)
                        sel_folded = sel_raw;
                else
                        sel_folded = REG_NONE;
        end

        assign decoded = '{
                known:   known,
                opcode:  opcode_t'(op_byte),
                operand: '{
                        reg_sel: sel_folded,
                        add_sel: instruction[ADD_MSB:ADD_LSB]
                }
        };

endmodule

/* hdl/micro_sequencer.sv */
module micro_sequencer (
        input  logic                     clk,
        input  logic                     rst_n,
        input  logic                     z,
        input  ctrl_pkg::decoded_instr_t decoded,
        output ctrl_pkg::ctrl_state_t    state,
        output ctrl_pkg::opcode_t        op_now,
        output logic                     dispatch
);
        import ctrl_pkg::*;

        ctrl_state_t next_state;
        ctrl_state_t entry_state;
        logic        take_jump;
        logic        cond_jump;

        assign dispatch = (state == ST_FETCH3);

        assign take_jump = (decoded.opcode == OP_JUMPZ) ? z : !z;   // JMNZ jumps on z low.
        assign cond_jump = (op_now == OP_JUMPZ) || (op_now == OP_JMNZ);

        // --------------------
        // Entry state

        // Unknown opcodes run through EXEC1 as NOP.
        always_comb
        begin
                entry_state = ST_EXEC1;
                if (decoded.known)
                begin
                        case (decoded.opcode)
                                OP_ADD:    entry_state = ST_ADD1;
                                OP_SUB:    entry_state = ST_SUB1;
                                OP_CLAC:   entry_state = ST_CLAC1;
                                OP_SFTR:   entry_state = ST_SFTR1;
                                OP_SFTL:   entry_state = ST_SFTL1;
                                OP_LDACAR: entry_state = ST_LDACAR1;
                                OP_JUMP:   entry_state = ST_JUMP1;
                                OP_ENDOP:  entry_state = ST_ENDOP;
                                OP_JUMPZ, OP_JMNZ:
                                        entry_state = take_jump ? ST_EXEC1 : ST_SKIP;
                                default:   entry_state = ST_EXEC1;
                        endcase
                end
        end

        // --------------------
        // Next state

        always_comb
        begin
                case (state)
                        ST_FETCH1:  next_state = ST_FETCH2;
                        ST_FETCH2:  next_state = ST_FETCH3;
                        ST_FETCH3:  next_state = entry_state;
                        ST_ADD1:    next_state = ST_ADD2;
                        ST_SUB1:    next_state = ST_SUB2;
                        ST_CLAC1, ST_SFTR1, ST_SFTL1:
                                next_state = ST_ALU_WB;
                        ST_LDACAR1: next_state = ST_LDACAR2;
                        ST_EXEC1:   next_state = cond_jump ? ST_JUMP1 : ST_FETCH1;
                        ST_JUMP1:   next_state = ST_JUMP2;
                        ST_JUMP2:   next_state = ST_JUMP3;
                        ST_ADD2, ST_SUB2, ST_ALU_WB, ST_LDACAR2, ST_JUMP3, ST_SKIP:
                                next_state = ST_FETCH1;
                        ST_ENDOP:   next_state = ST_ENDOP;      // Halted until reset.
                        default:    next_state = ST_FETCH1;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state  <= ST_FETCH1;
                        op_now <= OP_NOP;
                end
                else
                begin
                        state <= next_state;
                        if (dispatch)
                        begin
                                op_now <= decoded.known ? decoded.opcode : OP_NOP;
                        end
                end
        end

        // --------------------
        // Assertions

        state_legal: assert property (
                @(posedge clk) disable iff (!rst_n)
                !$isunknown(state) && state <= ST_ENDOP
        ) else $error("Microstate left the legal set.");

endmodule

/* hdl/operand_latch.sv */
module operand_latch (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               dispatch,
        input  ctrl_pkg::operand_t operand,
        output ctrl_pkg::operand_t held
);
        import ctrl_pkg::*;

        // The live instruction word moves on during jumps, so the operands
        // of the running instruction are kept here.
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        held <= '0;
                end
                else if (dispatch)
                begin
                        held <= operand;
                end
        end

        // --------------------
        // Assertions

        held_stable: assert property (
                @(posedge clk) disable iff (!rst_n)
                !dispatch |=> $stable(held)
        ) else $error("Operands changed without a dispatch.");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -f control_unit.f \
        --top-module control_unit_tb -o control_unit_sim
if [ $? -ne 0 ]; then
        echo "Build failed."
        exit 1
fi

./obj_dir/control_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status."
        exit 1
fi

if grep -qx ">>> PASS" "$log"; then
        exit 0
fi
echo "Pass message not found in $log."
exit 1

/* verification/control_unit_checks.sv */
module control_unit_checks #(
        parameter int PROG_LEN = 48
) (
        input logic                clk,
        input logic                rst_n,
        input logic                z,
        input ctrl_pkg::instr_t    instruction,
        input ctrl_pkg::instr_t    prog [PROG_LEN],
        input logic [PROG_LEN-1:0] z_plan,
        input ctrl_pkg::wr_en_t    write_enable,
        input ctrl_pkg::rd_sel_t   read_enable,
        input ctrl_pkg::inc_en_t   increment,
        input ctrl_pkg::alu_op_t   alu,
        input logic                finish
);
        import ctrl_pkg::*;

        int         word_errors = 0;
        int         halt_errors = 0;
        int         reset_errors = 0;
        int         input_errors = 0;
        ctrl_word_t got_word;
        ctrl_word_t exp_word;
        ctrl_word_t pending [$];
        int         next_pc;
        int         fetch_pc;      // Address of the word in its fetch.
        int         step;
        logic       at_dispatch;
        logic       halted;

        assign got_word = {write_enable, read_enable, increment, alu, finish};

        function automatic ctrl_word_t cw(wr_en_t wr, rd_sel_t rd, inc_en_t inc, alu_op_t op);
                ctrl_word_t w;
                w = {wr, rd, inc, op, 1'b0};
                return w;
        endfunction

        // --------------------
        // Expected words, one instruction at a time.

        task automatic expect_next_instr();
                instr_t   w;
                reg_sel_t sel;
                logic     valid;
                logic     taken;
                int       a;
                a = next_pc;
                fetch_pc = a;
                step = 0;
                w = prog[a];
                sel = w[3:0];
                valid = (sel >= 4'd1) && (sel <= 4'd11);
                pending.push_back(cw('0, RD_INS_MEM, '0, ALU_NO_OP));
                pending.push_back(cw(15'd1 << 2, RD_INS_MEM, '0, ALU_NO_OP));
                pending.push_back(cw('0, RD_NONE, 4'b0001, ALU_NO_OP));
                next_pc = a + 1;
                case (w[15:8])
                        OP_ADD:    pending.push_back(cw('0, (w[1:0] == 2'd0) ? RD_NONE :
                                           rd_sel_t'(w[1:0]) + 4'd9, '0, ALU_ADD));    // R is 10.
                        OP_SUB:    pending.push_back(cw('0, 4'd10, '0, ALU_SUB));
                        OP_CLAC:   pending.push_back(cw('0, RD_NONE, '0, ALU_ZERO));
                        OP_SFTR:   pending.push_back(cw('0, RD_NONE, '0, ALU_SFTR));
                        OP_SFTL:   pending.push_back(cw('0, RD_NONE, '0, ALU_SFTL));
                        OP_LDACAR:
                        begin
                                pending.push_back(cw(15'd1 << 13, RD_DATA_MEM, '0, ALU_NO_OP));
                                pending.push_back(cw(15'd1 << 14, 4'd14, '0, ALU_NO_OP));
                        end
                        OP_MVAC:   pending.push_back(cw(valid ? 15'd1 << (sel + 2) : '0,
                                           RD_AC, '0, ALU_NO_OP));
                        OP_MOVREG: pending.push_back(cw(15'd1 << 14, valid ? sel + 4'd3 : RD_NONE,
                                           '0, ALU_NO_OP));
                        OP_INCAC:  pending.push_back(cw('0, RD_NONE, 4'b0010, ALU_NO_OP));
                        OP_INCR:   pending.push_back(cw('0, RD_NONE, 4'b0100, ALU_NO_OP));
                        OP_INCR3:  pending.push_back(cw('0, RD_NONE, 4'b1000, ALU_NO_OP));
                        OP_JUMP, OP_JUMPZ, OP_JMNZ:
                        begin
                                taken = (w[15:8] == OP_JUMP) ||
                                        ((w[15:8] == OP_JUMPZ) == z_plan[a]);
                                if (w[15:8] != OP_JUMP && taken)
                                        pending.push_back(cw('0, RD_NONE, '0, ALU_NO_OP));
                                if (taken)
                                begin
                                        pending.push_back(cw('0, RD_INS_MEM, '0, ALU_NO_OP));
                                        pending.push_back(cw(15'd1 << 2, RD_INS_MEM, '0, ALU_NO_OP));
                                        pending.push_back(cw(15'd1 << 1, RD_NONE, '0, ALU_NO_OP));
                                        next_pc = int'(prog[a + 1][7:0]);
                                end
                                else
                                begin
                                        pending.push_back(cw('0, RD_NONE, 4'b0001, ALU_NO_OP));
                                        next_pc = a + 2;
                                end
                        end
                        OP_ENDOP:  halted = 1'b1;
                        default:   pending.push_back(cw('0, RD_NONE, '0, ALU_NO_OP));
                endcase
                if (w[15:8] inside {OP_ADD, OP_SUB, OP_CLAC, OP_SFTR, OP_SFTL})
                        pending.push_back(cw(15'd1, RD_NONE, '0, ALU_NO_OP));   // Write-back.
        endtask

        always @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        pending.delete();
                        halted = 1'b0;
                        next_pc = 0;
                        expect_next_instr();
                        exp_word <= pending.pop_front();
                        at_dispatch <= (step == 2);
                        step++;
                end
                else
                begin
                        if (pending.size() == 0)
                        begin
                                if (halted)
                                        pending.push_back({15'd0, RD_NONE, 4'd0, ALU_NO_OP, 1'b1});
                                else
                                        expect_next_instr();
                        end
                        exp_word <= pending.pop_front();
                        at_dispatch <= (step == 2);    // The third fetch cycle comes next.
                        step++;
                end
        end

        // --------------------
        // Assertions

        word_ok: assert property (@(posedge clk) disable iff (!rst_n) got_word == exp_word)
        else
        begin
                word_errors++;
                $display("Mismatch at %0t: control word %h, expected %h.", $time,
                         $sampled(got_word), $sampled(exp_word));
        end

        input_ok: assert property (@(posedge clk) disable iff (!rst_n)
                at_dispatch |-> instruction == prog[fetch_pc] && z == z_plan[fetch_pc])
        else
        begin
                input_errors++;
                $display("Mismatch at %0t: instruction or z at dispatch is not the program's.",
                         $time);
        end

        halt_ok: assert property (@(posedge clk) disable iff (!rst_n)
                finish |=> finish && write_enable == '0 && increment == '0)
        else
        begin
                halt_errors++;
                $display("Mismatch at %0t: the unit left its halt.", $time);
        end

        reset_ok: assert property (@(posedge clk) $rose(rst_n) |->
                write_enable == '0 && increment == '0 && !finish &&
                alu == ALU_NO_OP && read_enable == RD_INS_MEM)
        else
        begin
                reset_errors++;
                $display("Mismatch at %0t: outputs after reset are not the first fetch.", $time);
        end

endmodule

/* verification/control_unit_tb.sv */
module control_unit_tb;
        import ctrl_pkg::*;

        localparam int PROG_LEN = 48;
        localparam int CYCLE    = 8;

        logic                clk;
        logic                rst_n;
        logic                z;
        instr_t              instruction;
        wr_en_t              write_enable;
        rd_sel_t             read_enable;
        inc_en_t             increment;
        alu_op_t             alu;
        logic                finish;
        instr_t              prog [PROG_LEN];
        logic [PROG_LEN-1:0] z_plan;
        instr_t              ir;
        logic [7:0]          pc;
        wr_en_t              seen_wr;
        inc_en_t             seen_inc;
        int                  fill;
        int                  total;

        control_unit i_dut (.clk(clk), .rst_n(rst_n), .z(z), .instruction(instruction),
                .write_enable(write_enable), .read_enable(read_enable),
                .increment(increment), .alu(alu), .finish(finish));

        control_unit_checks #(.PROG_LEN(PROG_LEN)) i_checks (.clk(clk), .rst_n(rst_n),
                .z(z), .instruction(instruction), .prog(prog), .z_plan(z_plan),
                .write_enable(write_enable), .read_enable(read_enable),
                .increment(increment), .alu(alu), .finish(finish));

        always #(CYCLE / 2) clk = ~clk;

        task automatic put(input logic [7:0] op, input logic [7:0] low);
                prog[fill] = {op, low};
                fill++;
        endtask

        // Jump word, target word, then a pad word that only a fall-through runs.
        task automatic jump_block(input logic [7:0] op, input logic zv, input logic [7:0] pad);
                z_plan[fill] = zv;
                put(op, 8'd0);
                z_plan[fill] = !zv;                     // A late look at z sees the other value.
                put(8'd0, 8'(fill + 2));
                put(pad, 8'd0);
        endtask

        // --------------------
        // PC and IR model

        always @(negedge clk)
        begin
                seen_wr  = write_enable;
                seen_inc = increment;
        end

        always @(posedge clk)
        begin
                #1;
                if (seen_inc[INC_PC])
                        pc = pc + 8'd1;
                if (seen_wr[WR_IR])
                        ir = prog[pc];
                if (seen_wr[WR_IR_PC])
                        pc = ir[7:0];
                instruction = ir;
                z = z_plan[pc];
        end

        initial
        begin
                void'($urandom(27671));
                clk = 1'b0;
                rst_n = 1'b0;
                z = 1'b0;
                instruction = '0;
                ir = '0;
                pc = '0;
                seen_wr = '0;
                seen_inc = '0;
                fill = 0;
                for (int i = 0; i < PROG_LEN; i++)
                begin
                        prog[i] = {OP_ENDOP, 8'(i)};
                        z_plan[i] = 1'($urandom_range(1, 0));
                end
                put(OP_NOP, 8'd0);
                put(OP_ADD, 8'($urandom_range(3, 0)));
                put(OP_ADD, 8'($urandom_range(3, 1)));
                put(OP_SUB, 8'd0);
                put(OP_CLAC, 8'd0);
                put(OP_SFTR, 8'd0);
                put(OP_SFTL, 8'd0);
                put(OP_LDACAR, 8'd0);
                for (int i = 0; i < 3; i++)
                begin
                        put(OP_MVAC, 8'($urandom_range(15, 0)));
                        put(OP_MOVREG, 8'($urandom_range(15, 0)));
                end
                put(OP_MVAC, 8'd0);
                put(OP_MOVREG, 8'd13);
                put(OP_INCAC, 8'd0);
                put(OP_INCR, 8'd0);
                put(OP_INCR3, 8'd0);
                put(8'h77, 8'd0);                       // Not an opcode.
                jump_block(OP_JUMP, 1'b0, OP_ENDOP);
                jump_block(OP_JUMPZ, 1'b1, OP_INCAC);
                jump_block(OP_JMNZ, 1'b0, OP_INCAC);
                jump_block(OP_JUMPZ, 1'b0, OP_INCAC);
                jump_block(OP_JMNZ, 1'b1, OP_INCAC);
                jump_block($urandom_range(1, 0) ? OP_JUMPZ : OP_JMNZ, 1'($urandom_range(1, 0)),
                           OP_INCR);
                put(OP_ENDOP, 8'd0);

                repeat (10) @(posedge clk);
                #1 rst_n = 1'b1;
                wait (finish === 1'b1);
                repeat (6) @(posedge clk);
                total = i_checks.word_errors + i_checks.halt_errors + i_checks.reset_errors +
                        i_checks.input_errors;
                $display("Errors: word %0d, halt %0d, reset %0d, input %0d.",
                         i_checks.word_errors, i_checks.halt_errors, i_checks.reset_errors,
                         i_checks.input_errors);
                if (total == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

        initial
        begin
                #((PROG_LEN * 40 + 200) * CYCLE);
                $display("Timeout: the program never reached ENDOP.");
                $display(">>> FAIL");
                $finish;
        end

endmodule
